//--- mem_control.sv
`timescale 1ns/100ps

module mem_control
    (
        input  mips_pkg::ctrl_mem_t    i_ctrl_mem,
        input  mips_pkg::byte_off_t    i_addr_lo,
        input  logic                   i_alu_zero,
        output logic                   o_pcsrc,
        output logic                   o_misaligned,
        output mips_pkg::access_size_t o_size
    );

    logic access;
    logic half_bad;
    logic word_bad;

    ////////////////////
    // Branch resolution
    ////////////////////

    // BEQ takes on zero, BNE takes on non-zero
    always_comb
    begin
        if (i_ctrl_mem.bne)
            o_pcsrc = i_ctrl_mem.branch & ~i_alu_zero;
        else
            o_pcsrc = i_ctrl_mem.branch & i_alu_zero;
    end

    ////////////////////
    // Access size
    ////////////////////

    // Byte wins over half, word is the default
    always_comb
    begin
        if (i_ctrl_mem.sb || i_ctrl_mem.lb)
            o_size = mips_pkg::SIZE_BYTE;
        else if (i_ctrl_mem.sh || i_ctrl_mem.lh)
            o_size = mips_pkg::SIZE_HALF;
        else
            o_size = mips_pkg::SIZE_WORD;
    end

    ////////////////////
    // Alignment check
    ////////////////////

    // Only a real strobe can be misaligned
    assign access = i_ctrl_mem.mem_read | i_ctrl_mem.mem_write;

    // Halfword needs bit 0 clear
    assign half_bad = (o_size == mips_pkg::SIZE_HALF) && i_addr_lo[0];

    // Word needs both low bits clear
    assign word_bad = (o_size == mips_pkg::SIZE_WORD) && (|i_addr_lo);

    assign o_misaligned = access & (half_bad | word_bad);

endmodule

//--- mem_port.sv
`timescale 1ns/100ps

module mem_port
    #(
        parameter int RAM_DEPTH = 2048
    )
    (
        input  logic                   i_clk,
        input  logic                   i_rst,
        input  mips_pkg::ex_mem_t      i_ex_mem,
        input  mips_pkg::access_size_t i_size,
        input  logic                   i_misaligned,
        output mips_pkg::word_t        o_rd_word,
        output mips_pkg::rd_tag_t      o_rd_tag
    );

    mips_pkg::word_t    word_addr;
    mips_pkg::word_t    store_data;
    mips_pkg::byte_en_t lane_mask;
    mips_pkg::byte_en_t ram_be;
    mips_pkg::byte_off_t offset;
    logic               do_write;
    logic               ram_en;

    // Byte offset of the access
    assign offset = i_ex_mem.address[1:0];

    // Byte address to word index
    assign word_addr = {2'b00, i_ex_mem.address[mips_pkg::LEN-1:2]};

    ////////////////////
    // Store lanes
    ////////////////////

    // Narrow data copied into every lane it could land in
    always_comb
    begin
        case (i_size)
            mips_pkg::SIZE_BYTE: store_data = {4{i_ex_mem.write_data[7:0]}};
            mips_pkg::SIZE_HALF: store_data = {2{i_ex_mem.write_data[15:0]}};
            default:             store_data = i_ex_mem.write_data;
        endcase
    end

    // Lanes covered by the access
    always_comb
    begin
        case (i_size)
            mips_pkg::SIZE_BYTE: lane_mask = mips_pkg::byte_en_t'(4'b0001 << offset);
            mips_pkg::SIZE_HALF: lane_mask = offset[1] ? 4'b1100 : 4'b0011;
            default:             lane_mask = 4'b1111;
        endcase
    end

    ////////////////////
    // Enables
    ////////////////////

    // Misaligned access touches nothing
    assign do_write = i_ex_mem.ctrl_mem.mem_write & ~i_misaligned;
    assign ram_be   = do_write ? lane_mask : '0;

    // Held off during reset so nothing is written
    assign ram_en = i_rst & ~i_misaligned
                  & (i_ex_mem.ctrl_mem.mem_read | i_ex_mem.ctrl_mem.mem_write);

    ram_datos
    #(
        .RAM_DEPTH (RAM_DEPTH)
    )
    u_ram_datos
    (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_addr (word_addr),
        .i_din  (store_data),
        .i_en   (ram_en),
        .i_be   (ram_be),
        .o_dout (o_rd_word)
    );

    ////////////////////
    // Read tag
    ////////////////////

    // Same edge as the RAM read, so tag and word line up
    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
            o_rd_tag <= '0;
        else
        begin
            o_rd_tag.size        <= i_size;
            o_rd_tag.offset      <= offset;
            o_rd_tag.is_unsigned <= i_ex_mem.ctrl_mem.is_unsigned;
        end
    end

endmodule

//--- mem_wb_stage.sv
`timescale 1ns/100ps

module mem_wb_stage
    (
        input  logic                i_clk,
        input  logic                i_rst,
        input  mips_pkg::word_t     i_rd_word,
        input  mips_pkg::rd_tag_t   i_rd_tag,
        input  mips_pkg::ex_mem_t   i_ex_mem,
        input  logic                i_misaligned,
        output mips_pkg::mem_wb_t   o_mem_wb
    );

    // Pass-through fields, aligned with the RAM read
    mips_pkg::word_t     address_q;
    mips_pkg::reg_addr_t write_reg_q;
    mips_pkg::ctrl_wb_t  ctrl_wb_q;
    logic                misaligned_q;

    logic [7:0]          lane_byte;
    logic [15:0]         lane_half;
    mips_pkg::word_t     load_data;
    mips_pkg::mem_wb_t   mem_wb_d;

    ////////////////////
    // Rising-edge stage
    ////////////////////

    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
        begin
            address_q    <= '0;
            write_reg_q  <= '0;
            ctrl_wb_q    <= '0;
            misaligned_q <= 1'b0;
        end
        else
        begin
            address_q    <= i_ex_mem.address;
            write_reg_q  <= i_ex_mem.write_reg;
            ctrl_wb_q    <= i_ex_mem.ctrl_wb;
            misaligned_q <= i_misaligned;
        end
    end

    ////////////////////
    // Lane select, extend
    ////////////////////

    // Byte picked by offset, half by offset bit 1
    assign lane_byte = i_rd_word[8*i_rd_tag.offset +: 8];
    assign lane_half = i_rd_tag.offset[1] ? i_rd_word[31:16] : i_rd_word[15:0];

    // Sign comes from the top bit of the chosen lane
    always_comb
    begin
        case (i_rd_tag.size)
            mips_pkg::SIZE_BYTE:
            begin
                if (i_rd_tag.is_unsigned)
                    load_data = {24'b0, lane_byte};
                else
                    load_data = {{24{lane_byte[7]}}, lane_byte};
            end
            mips_pkg::SIZE_HALF:
            begin
                if (i_rd_tag.is_unsigned)
                    load_data = {16'b0, lane_half};
                else
                    load_data = {{16{lane_half[15]}}, lane_half};
            end
            default:
                load_data = i_rd_word;
        endcase
    end

    // Next MEM/WB value, bad access returns zero
    always_comb
    begin
        mem_wb_d.address    = address_q;
        mem_wb_d.read_data  = misaligned_q ? '0 : load_data;
        mem_wb_d.write_reg  = write_reg_q;
        mem_wb_d.ctrl_wb    = ctrl_wb_q;
        mem_wb_d.misaligned = misaligned_q;
    end

    ////////////////////
    // MEM/WB register
    ////////////////////

    // Falling edge, half a cycle after the read
    always_ff @(negedge i_clk)
    begin
        if (!i_rst)
            o_mem_wb <= '0;
        else
            o_mem_wb <= mem_wb_d;
    end

endmodule

//--- mips_pkg.sv
package mips_pkg;

    ////////////////////
    // Widths
    ////////////////////

    // Datapath width, data and byte address
    parameter int LEN = 32;
    // Register file index
    parameter int NB_REG_ADDR = 5;
    // Byte lanes per word
    parameter int NB_LANES = LEN / 8;
    // Data RAM depth in words
    parameter int RAM_DEPTH_DEFAULT = 2048;

    ////////////////////
    // Plain vector types
    ////////////////////

    typedef logic [LEN-1:0]         word_t;
    typedef logic [NB_REG_ADDR-1:0] reg_addr_t;
    typedef logic [NB_LANES-1:0]    byte_en_t;
    // Byte offset inside a word
    typedef logic [1:0]             byte_off_t;

    // Access width, decoded from the narrow store/load bits
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_t;

    ////////////////////
    // Control structs
    ////////////////////

    // Writeback control, passes through this stage untouched
    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
    } ctrl_wb_t;

    // Memory control, MSB first as the decoder packs it
    typedef struct packed {
        logic bne;
        logic sb;
        logic sh;
        logic lb;
        logic lh;
        logic is_unsigned;
        logic branch;
        logic mem_read;
        logic mem_write;
    } ctrl_mem_t;

    // EX/MEM pipeline values, stage input
    typedef struct packed {
        word_t     address;
        word_t     write_data;
        reg_addr_t write_reg;
        ctrl_wb_t  ctrl_wb;
        ctrl_mem_t ctrl_mem;
    } ex_mem_t;

    // MEM/WB pipeline values, stage output
    typedef struct packed {
        word_t     address;
        word_t     read_data;
        reg_addr_t write_reg;
        ctrl_wb_t  ctrl_wb;
        logic      misaligned;
    } mem_wb_t;

    // Follows the RAM read data so the extender knows the lane
    typedef struct packed {
        access_size_t size;
        byte_off_t    offset;
        logic         is_unsigned;
    } rd_tag_t;

endpackage

//--- ram_datos.sv
`timescale 1ns/100ps

module ram_datos
    #(
        parameter int RAM_DEPTH = 2048
    )
    (
        input  logic               i_clk,
        input  logic               i_rst,
        input  mips_pkg::word_t    i_addr,
        input  mips_pkg::word_t    i_din,
        input  logic               i_en,
        input  mips_pkg::byte_en_t i_be,
        output mips_pkg::word_t    o_dout
    );

    // Word index width
    localparam int NB_IDX = $clog2(RAM_DEPTH);

    // Storage, one word per entry
    mips_pkg::word_t mem [RAM_DEPTH];

    logic [NB_IDX-1:0] word_idx;

    // Word address, upper bits beyond depth ignored
    assign word_idx = i_addr[NB_IDX-1:0];

    ////////////////////
    // Write port
    ////////////////////

    // Each lane written only when its enable is set
    always_ff @(posedge i_clk)
    begin
        if (i_en)
        begin
            for (int b = 0; b < mips_pkg::NB_LANES; b++)
            begin
                if (i_be[b])
                    mem[word_idx][8*b +: 8] <= i_din[8*b +: 8];
            end
        end
    end

    ////////////////////
    // Registered read
    ////////////////////

    // Write-first per lane: written lanes return new data
    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
            o_dout <= '0;
        else if (i_en)
        begin
            for (int b = 0; b < mips_pkg::NB_LANES; b++)
            begin
                if (i_be[b])
                    o_dout[8*b +: 8] <= i_din[8*b +: 8];
                else
                    o_dout[8*b +: 8] <= mem[word_idx][8*b +: 8];
            end
        end
    end

endmodule

//--- tb.f
mips_pkg.sv
ram_datos.sv
mem_control.sv
mem_port.sv
mem_wb_stage.sv
tl_memory.sv
tl_memory_assertions.sv
tb_tl_memory.sv

//--- tb_tl_memory.sv
`timescale 1ns/100ps

module tb_tl_memory;

    localparam int RAM_DEPTH  = mips_pkg::RAM_DEPTH_DEFAULT;
    localparam int NB_IDX     = $clog2(RAM_DEPTH);
    localparam int CLK_PERIOD = 20;

    // Access size codes for the model
    localparam logic [1:0] SZ_B = 2'd0;
    localparam logic [1:0] SZ_H = 2'd1;
    localparam logic [1:0] SZ_W = 2'd2;

    // Cycle budget per test plus a watchdog margin
    localparam int CYC_RESET  = 6;
    localparam int CYC_WORD   = 34;
    localparam int CYC_LANES  = 102;
    localparam int CYC_BRANCH = 10;
    localparam int CYC_MIS    = 12;
    localparam int CYC_B2B    = 34;
    localparam int WATCHDOG_CYCLES = CYC_RESET + CYC_WORD + CYC_LANES + CYC_BRANCH
                                   + CYC_MIS + CYC_B2B + 40;

    localparam logic [31:0] LFSR_SEED = 32'h057b_0682;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic              clk = 1'b0;
    logic              rst;
    mips_pkg::ex_mem_t ex_mem;
    logic              alu_zero;
    mips_pkg::mem_wb_t mem_wb;
    logic              pcsrc;

    // Reference memory that predicts every load
    mips_pkg::word_t   shadow [RAM_DEPTH];
    logic [31:0]       lfsr;

    // Expected output of the instruction issued one cycle earlier
    mips_pkg::mem_wb_t pend_exp;
    logic              pend_data;
    logic              pend_valid;

    int checks;
    int errors;
    int tests;
    int failed_tests;

    tl_memory
    #(
        .RAM_DEPTH (RAM_DEPTH)
    )
    dut0
    (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_ex_mem   (ex_mem),
        .i_alu_zero (alu_zero),
        .o_mem_wb   (mem_wb),
        .o_pcsrc    (pcsrc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////

    // Galois LFSR stepped once per bit handed out
    function automatic mips_pkg::word_t rand_bits(input int n);
        mips_pkg::word_t val;
        logic            lsb;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb)
                lfsr = lfsr ^ LFSR_TAPS;
            val = {val[30:0], lsb};
        end
        return val;
    endfunction

    // Word-aligned byte address inside the RAM
    function automatic mips_pkg::word_t rand_addr();
        return rand_bits(NB_IDX) << 2;
    endfunction

    function automatic mips_pkg::ctrl_mem_t mem_ctrl(input logic rd, input logic wr,
                                                     input logic [1:0] sz, input logic uns);
        mips_pkg::ctrl_mem_t c;
        c             = '0;
        c.mem_read    = rd;
        c.mem_write   = wr;
        c.sb          = wr && (sz == SZ_B);
        c.sh          = wr && (sz == SZ_H);
        c.lb          = rd && (sz == SZ_B);
        c.lh          = rd && (sz == SZ_H);
        c.is_unsigned = uns;
        return c;
    endfunction

    task automatic check_val(input string name, input mips_pkg::word_t got,
                             input mips_pkg::word_t exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mem_wb(input mips_pkg::mem_wb_t exp, input logic chk_data);
        check_val("o_mem_wb.address", mem_wb.address, exp.address);
        if (chk_data)
            check_val("o_mem_wb.read_data", mem_wb.read_data, exp.read_data);
        check_val("o_mem_wb.write_reg", mem_wb.write_reg, exp.write_reg);
        check_val("o_mem_wb.ctrl_wb", mem_wb.ctrl_wb, exp.ctrl_wb);
        check_val("o_mem_wb.misaligned", mem_wb.misaligned, exp.misaligned);
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Lane rules applied to the shadow with stores first
    task automatic predict(input mips_pkg::ex_mem_t ex, output mips_pkg::mem_wb_t exp,
                           output logic chk);
        mips_pkg::ctrl_mem_t c;
        int unsigned         idx;
        int unsigned         lane;
        logic [1:0]          sz;
        logic                mis;
        mips_pkg::word_t     w;
        mips_pkg::word_t     ld;
        c    = ex.ctrl_mem;
        idx  = ex.address[NB_IDX+1:2];
        lane = ex.address[1:0];
        sz   = (c.sb || c.lb) ? SZ_B : ((c.sh || c.lh) ? SZ_H : SZ_W);
        mis  = (c.mem_read || c.mem_write)
             && (((sz == SZ_H) && ex.address[0]) || ((sz == SZ_W) && (ex.address[1:0] != 0)));
        w    = shadow[idx];
        ld   = '0;
        if (c.mem_write && !mis)
        begin
            case (sz)
                SZ_B:    w[8*lane +: 8]  = ex.write_data[7:0];
                SZ_H:    w[8*lane +: 16] = ex.write_data[15:0];
                default: w = ex.write_data;
            endcase
            shadow[idx] = w;
        end
        if (c.mem_read && !mis)
        begin
            case (sz)
                SZ_B:
                begin
                    ld = w[8*lane +: 8];
                    if (!c.is_unsigned && ld[7])
                        ld[31:8] = '1;
                end
                SZ_H:
                begin
                    ld = w[8*lane +: 16];
                    if (!c.is_unsigned && ld[15])
                        ld[31:16] = '1;
                end
                default: ld = w;
            endcase
        end
        exp            = '0;
        exp.address    = ex.address;
        exp.read_data  = ld;
        exp.write_reg  = ex.write_reg;
        exp.ctrl_wb    = ex.ctrl_wb;
        exp.misaligned = mis;
        // Stores and idle cycles leave read_data unspecified
        chk = mis || c.mem_read;
    endtask

    ////////////////////
    // Cycle driver
    ////////////////////

    // Entered 2 ns after a rising edge and left at the same point one cycle on
    task automatic cycle_op(input mips_pkg::ex_mem_t ex, input logic zero);
        mips_pkg::mem_wb_t exp_now;
        logic              data_now;
        logic              exp_pc;
        ex_mem   = ex;
        alu_zero = zero;
        predict(ex, exp_now, data_now);
        exp_pc = ex.ctrl_mem.branch
               && ((ex.ctrl_mem.bne && !zero) || (!ex.ctrl_mem.bne && zero));
        // Quarter cycle before the next rising edge
        #13;
        check_val("o_pcsrc", pcsrc, exp_pc);
        if (pend_valid)
            check_mem_wb(pend_exp, pend_data);
        pend_exp   = exp_now;
        pend_data  = data_now;
        pend_valid = 1'b1;
        @(posedge clk);
        #2;
    endtask

    // Random register and writeback bits ride along
    task automatic issue(input mips_pkg::word_t addr, input mips_pkg::word_t data,
                         input mips_pkg::ctrl_mem_t c, input logic zero);
        mips_pkg::ex_mem_t ex;
        mips_pkg::word_t   r;
        ex            = '0;
        ex.address    = addr;
        ex.write_data = data;
        ex.ctrl_mem   = c;
        r             = rand_bits(5);
        ex.write_reg  = r[4:0];
        r             = rand_bits(2);
        ex.ctrl_wb    = r[1:0];
        cycle_op(ex, zero);
    endtask

    task automatic end_test(input string name, input int err_start);
        tests++;
        if (errors == err_start)
            $display("test %s: ok", name);
        else
        begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_reset();
        int err_start;
        err_start = errors;
        @(posedge clk);
        @(posedge clk);
        #15;
        check_mem_wb('0, 1'b1);
        @(posedge clk);
        #2;
        rst = 1'b1;
        // First cycle out of reset must still read all zero
        cycle_op('0, 1'b0);
        #13;
        check_mem_wb('0, 1'b1);
        pend_valid = 1'b0;
        @(posedge clk);
        #2;
        end_test("reset", err_start);
    endtask

    task automatic test_word();
        int              err_start;
        mips_pkg::word_t addrs [16];
        mips_pkg::word_t data;
        err_start = errors;
        for (int i = 0; i < 16; i++)
        begin
            addrs[i] = rand_addr();
            data     = rand_bits(32);
            issue(addrs[i], data, mem_ctrl(1'b0, 1'b1, SZ_W, 1'b0), 1'b0);
        end
        for (int i = 0; i < 16; i++)
            issue(addrs[i], '0, mem_ctrl(1'b1, 1'b0, SZ_W, 1'b0), 1'b0);
        cycle_op('0, 1'b0);
        end_test("word_store_load", err_start);
    endtask

    task automatic test_lanes();
        int              err_start;
        mips_pkg::word_t base;
        mips_pkg::word_t data;
        err_start = errors;
        for (int n = 0; n < 4; n++)
        begin
            base = rand_addr();
            data = rand_bits(32);
            issue(base, data, mem_ctrl(1'b0, 1'b1, SZ_W, 1'b0), 1'b0);
            // Top bit alternates so both extensions get exercised
            for (int off = 0; off < 4; off++)
            begin
                data    = rand_bits(32);
                data[7] = off[0];
                issue(base + off, data, mem_ctrl(1'b0, 1'b1, SZ_B, 1'b0), 1'b0);
                issue(base, '0, mem_ctrl(1'b1, 1'b0, SZ_W, 1'b0), 1'b0);
                issue(base + off, '0, mem_ctrl(1'b1, 1'b0, SZ_B, 1'b0), 1'b0);
                issue(base + off, '0, mem_ctrl(1'b1, 1'b0, SZ_B, 1'b1), 1'b0);
            end
            for (int off = 0; off < 4; off += 2)
            begin
                data     = rand_bits(32);
                data[15] = off[1];
                issue(base + off, data, mem_ctrl(1'b0, 1'b1, SZ_H, 1'b0), 1'b0);
                issue(base, '0, mem_ctrl(1'b1, 1'b0, SZ_W, 1'b0), 1'b0);
                issue(base + off, '0, mem_ctrl(1'b1, 1'b0, SZ_H, 1'b0), 1'b0);
                issue(base + off, '0, mem_ctrl(1'b1, 1'b0, SZ_H, 1'b1), 1'b0);
            end
        end
        cycle_op('0, 1'b0);
        end_test("byte_half_lanes", err_start);
    endtask

    task automatic test_branch();
        int                  err_start;
        mips_pkg::ctrl_mem_t c;
        mips_pkg::word_t     addr;
        logic [2:0]          k;
        err_start = errors;
        // k is {branch, bne, alu_zero}
        for (int i = 0; i < 8; i++)
        begin
            k        = i[2:0];
            c        = '0;
            c.branch = k[2];
            c.bne    = k[1];
            addr     = rand_bits(32);
            issue(addr, '0, c, k[0]);
        end
        cycle_op('0, 1'b0);
        end_test("branch", err_start);
    endtask

    task automatic test_misaligned();
        int              err_start;
        mips_pkg::word_t base;
        mips_pkg::word_t data;
        err_start = errors;
        base = rand_addr();
        data = rand_bits(32);
        issue(base, data, mem_ctrl(1'b0, 1'b1, SZ_W, 1'b0), 1'b0);
        data = rand_bits(32);
        issue(base + 1, data, mem_ctrl(1'b0, 1'b1, SZ_H, 1'b0), 1'b0);
        issue(base + 3, data, mem_ctrl(1'b0, 1'b1, SZ_H, 1'b0), 1'b0);
        issue(base + 1, data, mem_ctrl(1'b0, 1'b1, SZ_W, 1'b0), 1'b0);
        issue(base + 2, data, mem_ctrl(1'b0, 1'b1, SZ_W, 1'b0), 1'b0);
        issue(base + 3, data, mem_ctrl(1'b0, 1'b1, SZ_W, 1'b0), 1'b0);
        issue(base + 1, '0, mem_ctrl(1'b1, 1'b0, SZ_H, 1'b0), 1'b0);
        issue(base + 3, '0, mem_ctrl(1'b1, 1'b0, SZ_H, 1'b1), 1'b0);
        issue(base + 2, '0, mem_ctrl(1'b1, 1'b0, SZ_W, 1'b0), 1'b0);
        // Aligned load shows the word survived
        issue(base, '0, mem_ctrl(1'b1, 1'b0, SZ_W, 1'b0), 1'b0);
        cycle_op('0, 1'b0);
        end_test("misaligned", err_start);
    endtask

    task automatic test_back_to_back();
        int              err_start;
        mips_pkg::word_t addr;
        mips_pkg::word_t data;
        err_start = errors;
        for (int i = 0; i < 8; i++)
        begin
            addr = rand_addr();
            data = rand_bits(32);
            issue(addr, data, mem_ctrl(1'b0, 1'b1, SZ_W, 1'b0), 1'b0);
            issue(addr, '0, mem_ctrl(1'b1, 1'b0, SZ_W, 1'b0), 1'b0);
            data = rand_bits(32);
            issue(addr + i[1:0], data, mem_ctrl(1'b0, 1'b1, SZ_B, 1'b0), 1'b0);
            issue(addr + i[1:0], '0, mem_ctrl(1'b1, 1'b0, SZ_B, 1'b1), 1'b0);
        end
        cycle_op('0, 1'b0);
        end_test("back_to_back", err_start);
    endtask

    ////////////////////
    // Sequence
    ////////////////////

    initial
    begin
        rst          = 1'b0;
        ex_mem       = '0;
        alu_zero     = 1'b0;
        lfsr         = LFSR_SEED;
        pend_exp     = '0;
        pend_data    = 1'b0;
        pend_valid   = 1'b0;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        test_reset();
        test_word();
        test_lanes();
        test_branch();
        test_misaligned();
        test_back_to_back();
        $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // Watchdog in case a test stalls
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

//--- tl_memory.sv
`timescale 1ns/100ps

module tl_memory
    #(
        parameter int RAM_DEPTH = mips_pkg::RAM_DEPTH_DEFAULT
    )
    (
        input  logic              i_clk,
        input  logic              i_rst,
        input  mips_pkg::ex_mem_t i_ex_mem,
        input  logic              i_alu_zero,
        output mips_pkg::mem_wb_t o_mem_wb,
        output logic              o_pcsrc
    );

    // Control to port and output stage
    mips_pkg::access_size_t size;
    logic                   misaligned;

    // Port to output stage
    mips_pkg::word_t        rd_word;
    mips_pkg::rd_tag_t      rd_tag;

    ////////////////////
    // Branch, alignment
    ////////////////////

    mem_control u_mem_control
    (
        .i_ctrl_mem   (i_ex_mem.ctrl_mem),
        .i_addr_lo    (i_ex_mem.address[1:0]),
        .i_alu_zero   (i_alu_zero),
        .o_pcsrc      (o_pcsrc),
        .o_misaligned (misaligned),
        .o_size       (size)
    );

    ////////////////////
    // RAM port
    ////////////////////

    mem_port
    #(
        .RAM_DEPTH (RAM_DEPTH)
    )
    u_mem_port
    (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_ex_mem     (i_ex_mem),
        .i_size       (size),
        .i_misaligned (misaligned),
        .o_rd_word    (rd_word),
        .o_rd_tag     (rd_tag)
    );

    ////////////////////
    // MEM/WB register
    ////////////////////

    mem_wb_stage u_mem_wb_stage
    (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_rd_word    (rd_word),
        .i_rd_tag     (rd_tag),
        .i_ex_mem     (i_ex_mem),
        .i_misaligned (misaligned),
        .o_mem_wb     (o_mem_wb)
    );

endmodule

//--- tl_memory_assertions.sv
`timescale 1ns/100ps

module tl_memory_assertions
    (
        input logic               i_clk,
        input logic               i_rst,
        input mips_pkg::ex_mem_t  i_ex_mem,
        input logic               i_pcsrc,
        input mips_pkg::mem_wb_t  i_mem_wb,
        input logic               i_misaligned,
        input mips_pkg::byte_en_t i_ram_be
    );

    ////////////////////
    // Branch select
    ////////////////////

    // PC source only moves for a branch
    a_pcsrc_needs_branch: assert property (@(posedge i_clk)
        i_pcsrc |-> i_ex_mem.ctrl_mem.branch)
        else $error("pcsrc high without a branch instruction");

    ////////////////////
    // Access gating
    ////////////////////

    // Misaligned access writes no lane
    a_no_be_misaligned: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_misaligned |-> (i_ram_be == '0))
        else $error("byte enable set on a misaligned access");

    // Output register cleared by reset
    a_reset_clears_out: assert property (@(posedge i_clk)
        $rose(i_rst) |-> (i_mem_wb == '0))
        else $error("MEM/WB output not zero right after reset");

endmodule

bind tl_memory tl_memory_assertions u_tl_memory_assertions
    (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_ex_mem     (i_ex_mem),
        .i_pcsrc      (o_pcsrc),
        .i_mem_wb     (o_mem_wb),
        .i_misaligned (misaligned),
        .i_ram_be     (u_mem_port.ram_be)
    );
